/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_processing \
    -f verilog.f --Mdir obj_dir -o sim_adc_processing > sim.log 2>&1 &&
    ./obj_dir/sim_adc_processing >> sim.log 2>&1 ||
    echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

/* src/adc_calibration.sv */
// Per-channel offset removal and optional arithmetic shift of ADC samples
`timescale 1ns/100ps

module adc_calibration import adc_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int N_CHANNELS = 4
) (
    input logic clock,
    input logic reset,
    input logic sample_valid,
    input logic [$clog2(N_CHANNELS)-1:0] sample_channel,
    input logic signed [DATA_WIDTH-1:0] sample_data,
    input logic signed [DATA_WIDTH-1:0] offset [N_CHANNELS],
    input logic [SHIFT_WIDTH-1:0] shift [N_CHANNELS],
    input logic shift_enable,
    output logic cal_valid,
    output logic [$clog2(N_CHANNELS)-1:0] cal_channel,
    output logic signed [DATA_WIDTH-1:0] cal_data
);

    logic signed [DATA_WIDTH-1:0] difference;
    logic signed [DATA_WIDTH-1:0] calibrated;

    // Subtraction wraps on overflow, there is no saturation stage
    always_comb begin
        difference = sample_data - offset[sample_channel];
        if (shift_enable) begin
            calibrated = difference >>> shift[sample_channel];
        end else begin
            calibrated = difference;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cal_valid <= 1'b0;
        end else begin
            cal_valid <= sample_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (sample_valid) begin
            cal_channel <= sample_channel;
            cal_data <= calibrated;
        end
    end

    // The upstream multiplexer must never present a channel without a configuration slot
    channel_in_range: assert property (
        @(posedge clock) disable iff (reset) sample_valid |-> sample_channel < N_CHANNELS
    );

endmodule

/* src/adc_pkg.sv */
// Package with register map, control bit positions, bus widths and the fault state type
package adc_pkg;

    // Wishbone data and byte address widths
    localparam int REGISTER_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 8;

    // Each channel owns a 4 bit shift field in REG_SHIFT
    localparam int SHIFT_WIDTH = 4;

    // The slow trip limit is an 8 bit field in REG_CONTROL
    localparam int SLOW_LIMIT_WIDTH = 8;

    // Word indices of the configuration registers
    localparam int REG_FAST_WINDOW = 0;
    localparam int REG_SLOW_WINDOW = 1;
    localparam int REG_OFFSET_BASE = 2;
    localparam int REG_SHIFT = 6;
    localparam int REG_CONTROL = 7;
    localparam int N_REGISTERS = 8;

    // Bit positions inside REG_CONTROL
    localparam int CTRL_SHIFT_ENABLE = 0;
    localparam int CTRL_LATCH_FAST = 1;
    localparam int CTRL_LATCH_SLOW = 2;
    localparam int CTRL_CLEAR_FAST = 3;
    localparam int CTRL_CLEAR_SLOW = 4;
    localparam int CTRL_SLOW_LIMIT_LSB = 8;
    localparam int CTRL_CLEAR_FAULT = 16;
    localparam int CTRL_DISABLE_FAULT = 17;

    typedef enum logic [1:0] {
        DISARMED = 2'd0,
        ARMED = 2'd1,
        TRIPPED = 2'd2
    } fault_state_t;

endpackage

/* src/adc_processing.sv */
// Top level of the ADC protection front end, wiring bus, calibration, comparators and fault logic
`timescale 1ns/100ps

module adc_processing import adc_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int N_CHANNELS = 4,
    parameter int STICKY_FAULT = 1
) (
    input logic clock,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [WB_ADDR_WIDTH-1:0] wb_adr,
    input logic [REGISTER_WIDTH-1:0] wb_dat_w,
    output logic [REGISTER_WIDTH-1:0] wb_dat_r,
    output logic wb_ack,
    input logic sample_valid,
    input logic [$clog2(N_CHANNELS)-1:0] sample_channel,
    input logic signed [DATA_WIDTH-1:0] sample_data,
    output logic cal_valid,
    output logic [$clog2(N_CHANNELS)-1:0] cal_channel,
    output logic signed [DATA_WIDTH-1:0] cal_data,
    output logic trip_fast,
    output logic trip_slow,
    output logic fault
);

    logic signed [DATA_WIDTH-1:0] fast_low, fast_high, slow_low, slow_high;
    logic signed [DATA_WIDTH-1:0] offset [N_CHANNELS];
    logic [SHIFT_WIDTH-1:0] shift [N_CHANNELS];
    logic shift_enable, latch_fast, latch_slow, clear_fast, clear_slow;
    logic clear_fault, disable_fault;
    logic [SLOW_LIMIT_WIDTH-1:0] slow_limit;
    logic count_enable, count_clear, limit_reached;

    wb_if bus ();

    // The external Wishbone master drives the request half of the bundle
    assign bus.cyc = wb_cyc;
    assign bus.stb = wb_stb;
    assign bus.we = wb_we;
    assign bus.adr = wb_adr;
    assign bus.dat_w = wb_dat_w;
    assign wb_dat_r = bus.dat_r;
    assign wb_ack = bus.ack;

    adc_register_file #(
        .DATA_WIDTH(DATA_WIDTH),
        .N_CHANNELS(N_CHANNELS)
    ) adc_register_file_i (
        .clock, .reset, .bus(bus.slave),
        .fast_low, .fast_high, .slow_low, .slow_high, .offset, .shift,
        .shift_enable, .latch_fast, .latch_slow, .clear_fast, .clear_slow,
        .clear_fault, .disable_fault, .slow_limit
    );

    adc_calibration #(
        .DATA_WIDTH(DATA_WIDTH),
        .N_CHANNELS(N_CHANNELS)
    ) adc_calibration_i (
        .clock, .reset, .sample_valid, .sample_channel, .sample_data,
        .offset, .shift, .shift_enable, .cal_valid, .cal_channel, .cal_data
    );

    trip_comparator #(
        .DATA_WIDTH(DATA_WIDTH)
    ) trip_comparator_i (
        .clock, .reset, .cal_valid, .cal_data,
        .fast_low, .fast_high, .slow_low, .slow_high,
        .latch_fast, .latch_slow, .clear_fast, .clear_slow, .trip_fast, .trip_slow
    );

    slow_trip_counter slow_trip_counter_i (
        .clock, .reset, .count_enable, .count_clear, .limit(slow_limit), .limit_reached
    );

    fault_fsm #(
        .STICKY_FAULT(STICKY_FAULT)
    ) fault_fsm_i (
        .clock, .reset, .sample_valid, .trip_fast, .trip_slow, .clear_fault,
        .disable_fault, .limit_reached, .count_enable, .count_clear, .fault
    );

endmodule

/* src/adc_register_file.sv */
// Wishbone slave register file and decoding of the configuration fields
`timescale 1ns/100ps

module adc_register_file import adc_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int N_CHANNELS = 4
) (
    input logic clock,
    input logic reset,
    wb_if.slave bus,
    output logic signed [DATA_WIDTH-1:0] fast_low,
    output logic signed [DATA_WIDTH-1:0] fast_high,
    output logic signed [DATA_WIDTH-1:0] slow_low,
    output logic signed [DATA_WIDTH-1:0] slow_high,
    output logic signed [DATA_WIDTH-1:0] offset [N_CHANNELS],
    output logic [SHIFT_WIDTH-1:0] shift [N_CHANNELS],
    output logic shift_enable,
    output logic latch_fast,
    output logic latch_slow,
    output logic clear_fast,
    output logic clear_slow,
    output logic clear_fault,
    output logic disable_fault,
    output logic [SLOW_LIMIT_WIDTH-1:0] slow_limit
);

    localparam int INDEX_WIDTH = $clog2(N_REGISTERS);
    localparam int HIGH_LSB = REGISTER_WIDTH / 2;

    logic [REGISTER_WIDTH-1:0] regs [N_REGISTERS];
    logic [INDEX_WIDTH-1:0] index;
    logic in_range;
    logic served;
    logic request;

    // Address bits 1..0 select a byte and are ignored while all bits above the index must be zero
    assign index = bus.adr[2 +: INDEX_WIDTH];
    assign in_range = (bus.adr >> (2 + INDEX_WIDTH)) == '0;

    // A new request is only taken once stb has been dropped after the previous ack
    assign request = bus.cyc && bus.stb && !served;

    always_ff @(posedge clock) begin
        if (reset) begin
            bus.ack <= 1'b0;
            served <= 1'b0;
            for (int i = 0; i < N_REGISTERS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            bus.ack <= request;
            if (!(bus.cyc && bus.stb)) begin
                served <= 1'b0;
            end else if (request) begin
                served <= 1'b1;
            end
            if (request && bus.we && in_range) begin
                regs[index] <= bus.dat_w;
            end
        end
    end

    // Readback is captured on the acknowledging edge and holes in the map read zero
    always_ff @(posedge clock) begin
        if (request) begin
            bus.dat_r <= (!bus.we && in_range) ? regs[index] : '0;
        end
    end

    assign fast_low = regs[REG_FAST_WINDOW][DATA_WIDTH-1:0];
    assign fast_high = regs[REG_FAST_WINDOW][HIGH_LSB +: DATA_WIDTH];
    assign slow_low = regs[REG_SLOW_WINDOW][DATA_WIDTH-1:0];
    assign slow_high = regs[REG_SLOW_WINDOW][HIGH_LSB +: DATA_WIDTH];

    for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_channel
        assign offset[ch] = regs[REG_OFFSET_BASE + ch][DATA_WIDTH-1:0];
        assign shift[ch] = regs[REG_SHIFT][ch * SHIFT_WIDTH +: SHIFT_WIDTH];
    end

    assign shift_enable = regs[REG_CONTROL][CTRL_SHIFT_ENABLE];
    assign latch_fast = regs[REG_CONTROL][CTRL_LATCH_FAST];
    assign latch_slow = regs[REG_CONTROL][CTRL_LATCH_SLOW];
    assign clear_fast = regs[REG_CONTROL][CTRL_CLEAR_FAST];
    assign clear_slow = regs[REG_CONTROL][CTRL_CLEAR_SLOW];
    assign slow_limit = regs[REG_CONTROL][CTRL_SLOW_LIMIT_LSB +: SLOW_LIMIT_WIDTH];
    assign clear_fault = regs[REG_CONTROL][CTRL_CLEAR_FAULT];
    assign disable_fault = regs[REG_CONTROL][CTRL_DISABLE_FAULT];

    // Each transfer gets exactly one ack cycle
    ack_single_cycle: assert property (
        @(posedge clock) disable iff (reset) bus.ack |=> !bus.ack
    );

endmodule

/* src/fault_fsm.sv */
// Fault state machine with arming, fast and counted slow trips, sticky or non-sticky release
`timescale 1ns/100ps

module fault_fsm import adc_pkg::*; #(
    parameter int STICKY_FAULT = 1
) (
    input logic clock,
    input logic reset,
    input logic sample_valid,
    input logic trip_fast,
    input logic trip_slow,
    input logic clear_fault,
    input logic disable_fault,
    input logic limit_reached,
    output logic count_enable,
    output logic count_clear,
    output logic fault
);

    fault_state_t state_q;
    fault_state_t state_next;
    logic no_trip;
    logic release_fault;

    assign no_trip = !trip_fast && !trip_slow;

    // Sticky mode also needs software to acknowledge the fault
    assign release_fault = no_trip && (STICKY_FAULT == 0 || clear_fault);

    // Slow trips are counted only while armed and not overridden by a fast trip
    assign count_enable = (state_q == ARMED) && trip_slow && !trip_fast;

    always_comb begin
        state_next = state_q;
        case (state_q)
            DISARMED: if (sample_valid) state_next = ARMED;
            ARMED: begin
                if (trip_fast || (trip_slow && limit_reached)) begin
                    state_next = TRIPPED;
                end
            end
            TRIPPED: if (release_fault) state_next = ARMED;
            default: state_next = DISARMED;
        endcase
        if (disable_fault) begin
            state_next = DISARMED;
        end
    end

    assign count_clear = (state_q == DISARMED) || (state_q == TRIPPED && state_next != TRIPPED);

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= DISARMED;
            fault <= 1'b0;
        end else begin
            state_q <= state_next;
            fault <= (state_next == TRIPPED);
        end
    end

    // In sticky mode a fault is only released by clear_fault or disable_fault
    sticky_fault_held: assert property (
        @(posedge clock) disable iff (reset)
        STICKY_FAULT != 0 && fault && !clear_fault && !disable_fault |=> fault
    );

endmodule

/* src/slow_trip_counter.sv */
// Slow trip event counter with a programmable limit
`timescale 1ns/100ps

module slow_trip_counter import adc_pkg::*; (
    input logic clock,
    input logic reset,
    input logic count_enable,
    input logic count_clear,
    input logic [SLOW_LIMIT_WIDTH-1:0] limit,
    output logic limit_reached
);

    logic [SLOW_LIMIT_WIDTH-1:0] count;

    always_ff @(posedge clock) begin
        if (reset || count_clear) begin
            count <= '0;
        end else if (count_enable) begin
            count <= count + 1'b1;
        end
    end

    // A limit of zero wraps to all ones here, which makes the 256th event the last one
    assign limit_reached = count_enable && (count == limit - 1'b1);

endmodule

/* src/trip_comparator.sv */
// Fast and slow trip window comparators with optional latching of each trip
`timescale 1ns/100ps

module trip_comparator #(
    parameter int DATA_WIDTH = 16
) (
    input logic clock,
    input logic reset,
    input logic cal_valid,
    input logic signed [DATA_WIDTH-1:0] cal_data,
    input logic signed [DATA_WIDTH-1:0] fast_low,
    input logic signed [DATA_WIDTH-1:0] fast_high,
    input logic signed [DATA_WIDTH-1:0] slow_low,
    input logic signed [DATA_WIDTH-1:0] slow_high,
    input logic latch_fast,
    input logic latch_slow,
    input logic clear_fast,
    input logic clear_slow,
    output logic trip_fast,
    output logic trip_slow
);

    localparam int N_WINDOWS = 2;
    localparam int FAST = 0;
    localparam int SLOW = 1;

    logic signed [DATA_WIDTH-1:0] low [N_WINDOWS];
    logic signed [DATA_WIDTH-1:0] high [N_WINDOWS];
    logic latch [N_WINDOWS];
    logic clear [N_WINDOWS];
    logic hit [N_WINDOWS];
    logic trip_q [N_WINDOWS];

    assign low[FAST] = fast_low;
    assign high[FAST] = fast_high;
    assign latch[FAST] = latch_fast;
    assign clear[FAST] = clear_fast;
    assign low[SLOW] = slow_low;
    assign high[SLOW] = slow_high;
    assign latch[SLOW] = latch_slow;
    assign clear[SLOW] = clear_slow;

    // Both windows use the same logic, only their thresholds and control bits differ
    for (genvar w = 0; w < N_WINDOWS; w++) begin : g_window
        // A sample sitting exactly on a threshold is still inside the window
        assign hit[w] = cal_valid && (cal_data > high[w] || cal_data < low[w]);

        always_ff @(posedge clock) begin
            if (reset) begin
                trip_q[w] <= 1'b0;
            end else if (!latch[w]) begin
                trip_q[w] <= hit[w];
            end else if (clear[w]) begin
                trip_q[w] <= 1'b0;
            end else if (hit[w]) begin
                trip_q[w] <= 1'b1;
            end
        end
    end

    assign trip_fast = trip_q[FAST];
    assign trip_slow = trip_q[SLOW];

endmodule

/* src/wb_if.sv */
// Wishbone classic bus interface with master and slave modports
`timescale 1ns/100ps

interface wb_if import adc_pkg::*; ();

    // Request side, held by the master until ack
    logic cyc;
    logic stb;
    logic we;
    logic [WB_ADDR_WIDTH-1:0] adr;
    logic [REGISTER_WIDTH-1:0] dat_w;

    // Response side, ack lasts a single cycle
    logic [REGISTER_WIDTH-1:0] dat_r;
    logic ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input dat_r, ack
    );

    modport slave (
        input cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

/* tests/tb_adc_processing.sv */
// Testbench for the ADC protection front end with a stimulus table, Wishbone tasks and a watchdog
`timescale 1ns/100ps

module tb_adc_processing import adc_pkg::*; ();

    localparam int DATA_WIDTH = 16;
    localparam int N_CHANNELS = 4;
    localparam int CHANNEL_WIDTH = $clog2(N_CHANNELS);
    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    localparam int CYCLES_PER_ENTRY = 20;

    localparam logic [2:0] OP_WRITE = 3'd0;
    localparam logic [2:0] OP_READ = 3'd1;
    localparam logic [2:0] OP_SAMPLE = 3'd2;
    localparam logic [2:0] OP_RANDOM = 3'd3;
    localparam logic [2:0] OP_STATUS = 3'd4;

    // The target holds a byte address for bus ops and a channel for sample ops
    // Status values are {fault, trip_fast, trip_slow}
    typedef struct packed {
        logic [2:0] op;
        logic [7:0] target;
        logic [31:0] data;
        logic [31:0] expected;
    } entry_t;

    logic clock;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [WB_ADDR_WIDTH-1:0] wb_adr;
    logic [REGISTER_WIDTH-1:0] wb_dat_w;
    logic [REGISTER_WIDTH-1:0] wb_dat_r;
    logic wb_ack;
    logic sample_valid;
    logic [CHANNEL_WIDTH-1:0] sample_channel;
    logic signed [DATA_WIDTH-1:0] sample_data;
    logic cal_valid;
    logic [CHANNEL_WIDTH-1:0] cal_channel;
    logic signed [DATA_WIDTH-1:0] cal_data;
    logic trip_fast;
    logic trip_slow;
    logic fault;

    entry_t steps [$];
    logic steps_ready;
    int errors;
    integer seed;
    logic [REGISTER_WIDTH-1:0] shadow [N_REGISTERS];

    adc_processing #(
        .DATA_WIDTH(DATA_WIDTH),
        .N_CHANNELS(N_CHANNELS),
        .STICKY_FAULT(1)
    ) adc_processing_i (
        .clock, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .sample_valid, .sample_channel, .sample_data, .cal_valid, .cal_channel, .cal_data,
        .trip_fast, .trip_slow, .fault
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic void add_step(input logic [2:0] op, input int target,
                                     input logic [31:0] data, input logic [31:0] expected);
        entry_t step;
        step.op = op;
        step.target = 8'(target);
        step.data = data;
        step.expected = expected;
        steps.push_back(step);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    endtask

    // Reference calibration built from the shadow copy of the written registers
    function automatic logic signed [DATA_WIDTH-1:0] expected_cal(
        input int channel,
        input logic signed [DATA_WIDTH-1:0] data
    );
        logic signed [DATA_WIDTH-1:0] result;
        logic [SHIFT_WIDTH-1:0] amount;
        result = data - shadow[REG_OFFSET_BASE + channel][DATA_WIDTH-1:0];
        amount = shadow[REG_SHIFT][channel * SHIFT_WIDTH +: SHIFT_WIDTH];
        if (shadow[REG_CONTROL][CTRL_SHIFT_ENABLE]) begin
            result = result >>> amount;
        end
        return result;
    endfunction

    task automatic bus_transfer(input logic write, input logic [WB_ADDR_WIDTH-1:0] addr,
                                input logic [REGISTER_WIDTH-1:0] write_data,
                                output logic [REGISTER_WIDTH-1:0] read_data);
        @(posedge clock);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= write;
        wb_adr <= addr;
        wb_dat_w <= write_data;
        // Ack and read data change on the rising edge and are sampled on the falling edge
        do begin
            @(negedge clock);
        end while (wb_ack !== 1'b1);
        read_data = wb_dat_r;
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_WIDTH-1:0] addr,
                            input logic [REGISTER_WIDTH-1:0] data);
        logic [REGISTER_WIDTH-1:0] ignored;
        bus_transfer(1'b1, addr, data, ignored);
    endtask

    task automatic wb_read(input logic [WB_ADDR_WIDTH-1:0] addr,
                           output logic [REGISTER_WIDTH-1:0] data);
        bus_transfer(1'b0, addr, '0, data);
    endtask

    // Cal outputs follow the sample by one cycle and trips and fault by one more cycle each
    task automatic apply_sample(input int channel, input logic signed [DATA_WIDTH-1:0] data,
                                input logic [2:0] status);
        logic signed [DATA_WIDTH-1:0] model;
        model = expected_cal(channel, data);
        @(posedge clock);
        sample_valid <= 1'b1;
        sample_channel <= channel[CHANNEL_WIDTH-1:0];
        sample_data <= data;
        @(posedge clock);
        sample_valid <= 1'b0;
        @(negedge clock);
        if (cal_valid !== 1'b1) report_mismatch("cal_valid", 1, cal_valid);
        if (cal_channel !== channel[CHANNEL_WIDTH-1:0]) begin
            report_mismatch("cal_channel", channel, cal_channel);
        end
        if (cal_data !== model) report_mismatch("cal_data", model, cal_data);
        @(negedge clock);
        if (trip_fast !== status[1]) report_mismatch("trip_fast", status[1], trip_fast);
        if (trip_slow !== status[0]) report_mismatch("trip_slow", status[0], trip_slow);
        @(negedge clock);
        if (fault !== status[2]) report_mismatch("fault", status[2], fault);
    endtask

    task automatic check_status(input logic [2:0] status);
        @(negedge clock);
        if (fault !== status[2]) report_mismatch("fault", status[2], fault);
        if (trip_fast !== status[1]) report_mismatch("trip_fast", status[1], trip_fast);
        if (trip_slow !== status[0]) report_mismatch("trip_slow", status[0], trip_slow);
    endtask

    initial begin
        logic [REGISTER_WIDTH-1:0] read_data;
        int index;
        int value;
        clock = 1'b0;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        sample_valid = 1'b0;
        sample_channel = '0;
        sample_data = '0;
        steps_ready = 1'b0;
        errors = 0;
        seed = 94;
        for (int i = 0; i < N_REGISTERS; i++) begin
            shadow[i] = '0;
        end

        // Register map with a fast window of -1000..1000 and a slow window of -300..300
        add_step(OP_READ, REG_CONTROL * 4, 0, 32'h0);
        add_step(OP_WRITE, REG_FAST_WINDOW * 4, 32'h03E8FC18, 0);
        add_step(OP_READ, REG_FAST_WINDOW * 4, 0, 32'h03E8FC18);
        add_step(OP_WRITE, REG_SLOW_WINDOW * 4, 32'h012CFED4, 0);
        add_step(OP_READ, REG_SLOW_WINDOW * 4, 0, 32'h012CFED4);
        add_step(OP_WRITE, (REG_OFFSET_BASE + 0) * 4, 32'h0000000A, 0);
        add_step(OP_WRITE, (REG_OFFSET_BASE + 1) * 4, 32'h0000FFEC, 0);
        add_step(OP_WRITE, (REG_OFFSET_BASE + 2) * 4, 32'h00000064, 0);
        add_step(OP_WRITE, (REG_OFFSET_BASE + 3) * 4, 32'h0000FF38, 0);
        add_step(OP_READ, (REG_OFFSET_BASE + 0) * 4, 0, 32'h0000000A);
        add_step(OP_READ, (REG_OFFSET_BASE + 1) * 4, 0, 32'h0000FFEC);
        add_step(OP_READ, (REG_OFFSET_BASE + 2) * 4, 0, 32'h00000064);
        add_step(OP_READ, (REG_OFFSET_BASE + 3) * 4, 0, 32'h0000FF38);
        add_step(OP_WRITE, REG_SHIFT * 4, 32'h00003210, 0);
        add_step(OP_READ, REG_SHIFT * 4, 0, 32'h00003210);
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00000300, 0);
        add_step(OP_READ, REG_CONTROL * 4, 0, 32'h00000300);
        add_step(OP_WRITE, N_REGISTERS * 4, 32'hDEADBEEF, 0);
        add_step(OP_READ, N_REGISTERS * 4, 0, 32'h0);
        // Calibration without and with the per-channel shift
        add_step(OP_SAMPLE, 0, 32'd50, 3'b000);
        add_step(OP_SAMPLE, 1, 32'd30, 3'b000);
        add_step(OP_SAMPLE, 2, 32'(-40), 3'b000);
        add_step(OP_SAMPLE, 3, 32'd60, 3'b000);
        add_step(OP_RANDOM, 2, 0, 3'b000);
        add_step(OP_RANDOM, 3, 0, 3'b000);
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00000301, 0);
        add_step(OP_SAMPLE, 0, 32'd250, 3'b000);
        add_step(OP_SAMPLE, 1, 32'(-450), 3'b000);
        add_step(OP_SAMPLE, 2, 32'd700, 3'b000);
        add_step(OP_SAMPLE, 3, 32'(-1000), 3'b000);
        add_step(OP_RANDOM, 1, 0, 3'b000);
        add_step(OP_RANDOM, 0, 0, 3'b000);
        // A fast trip raises a sticky fault that only goes away with clear_fault
        add_step(OP_SAMPLE, 0, 32'd2000, 3'b111);
        add_step(OP_STATUS, 0, 0, 3'b100);
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00010301, 0);
        add_step(OP_STATUS, 0, 0, 3'b000);
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00000301, 0);
        // Three slow trips with a limit of 3
        add_step(OP_SAMPLE, 0, 32'd500, 3'b001);
        add_step(OP_SAMPLE, 0, 32'd500, 3'b001);
        add_step(OP_SAMPLE, 0, 32'd500, 3'b101);
        add_step(OP_STATUS, 0, 0, 3'b100);
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00010301, 0);
        add_step(OP_STATUS, 0, 0, 3'b000);
        // Latched slow trip while the fault logic is disabled
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00020305, 0);
        add_step(OP_READ, REG_CONTROL * 4, 0, 32'h00020305);
        add_step(OP_SAMPLE, 0, 32'd500, 3'b001);
        add_step(OP_STATUS, 0, 0, 3'b001);
        add_step(OP_SAMPLE, 0, 32'd2000, 3'b011);
        add_step(OP_STATUS, 0, 0, 3'b001);
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00020315, 0);
        add_step(OP_STATUS, 0, 0, 3'b000);
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00020305, 0);
        add_step(OP_STATUS, 0, 0, 3'b000);
        add_step(OP_WRITE, REG_CONTROL * 4, 32'h00000301, 0);
        add_step(OP_RANDOM, 3, 0, 3'b000);
        add_step(OP_SAMPLE, 0, 32'd2000, 3'b111);
        add_step(OP_STATUS, 0, 0, 3'b100);
        steps_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (wb_ack !== 1'b0) report_mismatch("wb_ack", 0, wb_ack);
        if (cal_valid !== 1'b0) report_mismatch("cal_valid", 0, cal_valid);
        check_status(3'b000);

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WRITE: begin
                    wb_write(steps[i].target, steps[i].data);
                    index = int'(steps[i].target) / 4;
                    if (index < N_REGISTERS) begin
                        shadow[index] = steps[i].data;
                    end
                end
                OP_READ: begin
                    wb_read(steps[i].target, read_data);
                    if (read_data !== steps[i].expected) begin
                        report_mismatch($sformatf("wb_dat_r[0x%0h]", steps[i].target),
                                        steps[i].expected, read_data);
                    end
                end
                OP_SAMPLE: apply_sample(int'(steps[i].target), steps[i].data[DATA_WIDTH-1:0],
                                        steps[i].expected[2:0]);
                OP_RANDOM: begin
                    // Small values keep every channel inside both windows
                    value = $random(seed) % 100;
                    apply_sample(int'(steps[i].target), DATA_WIDTH'(value),
                                 steps[i].expected[2:0]);
                end
                OP_STATUS: check_status(steps[i].expected[2:0]);
                default: begin
                    errors++;
                    $display("Table entry %0d holds an unknown operation %0d", i, steps[i].op);
                end
            endcase
        end

        $display("Ran %0d table entries, error count %0d", steps.size(), errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog scaled to the table length
    initial begin
        wait (steps_ready === 1'b1);
        #(steps.size() * CYCLES_PER_ENTRY * CLOCK_PERIOD + 1000);
        $display("Timeout: the table did not complete in time, %0d errors so far", errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* verilog.f */
src/adc_pkg.sv
src/wb_if.sv
src/adc_register_file.sv
src/adc_calibration.sv
src/trip_comparator.sv
src/slow_trip_counter.sv
src/fault_fsm.sv
src/adc_processing.sv
tests/tb_adc_processing.sv
